// File: compile.f
+incdir+dv
rtl/core_pkg.sv
rtl/isa_pkg.sv
rtl/core_if.sv
rtl/issue_stage.sv
rtl/scoreboard.sv
rtl/regfile.sv
rtl/exec_alu.sv
rtl/exec_mul.sv
rtl/iss_top.sv
dv/tb_top.sv

// File: dv/tb_tests.svh
// ==================================================
// reference register model and instruction encoders
// directed tests for reset, alu, x0, multiplier hazard,
// burst back-pressure and random program
// ==================================================
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

  data_t model_regs [reg_els_c];

  function automatic data_t encode_rr(input opcode_e op, input reg_id_t rd,
                                      input reg_id_t rs1, input reg_id_t rs2);
    return {op, rd, rs1, rs2, 16'h0000};
  endfunction

  function automatic data_t encode_ri(input opcode_e op, input reg_id_t rd,
                                      input reg_id_t rs1, input logic [19:0] imm);
    return {op, rd, rs1, imm};
  endfunction

  // program order, wrapped arithmetic, x0 writes dropped
  task automatic model_apply(input data_t word);
    reg_id_t rd;
    data_t   a;
    data_t   b;
    data_t   imm;
    data_t   res;
    logic    writes;
    rd     = word[27:24];
    a      = model_regs[word[23:20]];
    b      = model_regs[word[19:16]];
    imm    = {{12{word[19]}}, word[19:0]};
    writes = 1'b1;
    res    = '0;
    case (word[31:28])
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_XOR:  res = a ^ b;
      OP_ADDI: res = a + imm;
      OP_MUL:  res = a * b;
      default: writes = 1'b0;
    endcase
    if (writes && rd != 0) begin
      model_regs[rd] = res;
    end
  endtask

  task automatic issue(input data_t word);
    wb_write(addr_instr_c, word);
    model_apply(word);
  endtask

  task automatic wait_idle();
    data_t st;
    int    polls;
    st    = '1;
    polls = 0;
    while (st[status_busy_c] && polls < max_polls_c) begin
      wb_read(addr_status_c, st);
      polls++;
    end
    if (st[status_busy_c]) begin
      $display("status still busy after %0d polls at %0t ns", polls, $time);
      err_count++;
    end
  endtask

  task automatic compare_regs();
    data_t val;
    for (int r = 0; r < reg_els_c; r++) begin
      wb_read(addr_t'(addr_reg_base_c + r), val);
      check($sformatf("x%0d", r), val, model_regs[r]);
    end
  endtask

  task automatic reset_state();
    int    errs;
    data_t st;
    errs = err_count;
    for (int r = 0; r < reg_els_c; r++) begin
      model_regs[r] = '0;
    end
    wb_read(addr_status_c, st);
    check("status busy", data_t'(st[status_busy_c]), '0);
    compare_regs();
    end_test("reset_state", errs);
  endtask

  task automatic alu_chains();
    int errs;
    errs = err_count;
    issue(encode_ri(OP_ADDI, 1, 0, 20'h00123));
    // -10 and the most negative immediate
    issue(encode_ri(OP_ADDI, 2, 0, 20'hffff6));
    issue(encode_rr(OP_ADD, 3, 1, 2));
    issue(encode_rr(OP_SUB, 4, 2, 1));
    issue(encode_rr(OP_XOR, 5, 3, 4));
    issue(encode_ri(OP_ADDI, 6, 5, 20'h80000));
    issue(encode_rr(OP_SUB, 7, 0, 6));
    issue(encode_rr(OP_ADD, 7, 7, 7));
    wait_idle();
    compare_regs();
    end_test("alu_chains", errs);
  endtask

  task automatic x0_handling();
    int errs;
    errs = err_count;
    issue(encode_ri(OP_ADDI, 0, 1, 20'h00055));
    issue(encode_rr(OP_ADD, 0, 1, 2));
    issue(encode_rr(OP_MUL, 0, 1, 1));
    issue(encode_rr(OP_ADD, 8, 0, 1));
    issue(encode_rr(OP_XOR, 9, 1, 0));
    wait_idle();
    compare_regs();
    end_test("x0_handling", errs);
  endtask

  task automatic mul_hazard();
    int errs;
    errs = err_count;
    issue(encode_ri(OP_ADDI, 10, 0, 20'h01234));
    issue(encode_ri(OP_ADDI, 11, 0, 20'hffffd));
    issue(encode_rr(OP_MUL, 12, 10, 11));
    // readers of x12 right behind the multiply
    issue(encode_rr(OP_ADD, 13, 12, 10));
    issue(encode_rr(OP_ADD, 14, 12, 12));
    issue(encode_rr(OP_MUL, 12, 12, 11));
    // pure write-after-write on x12
    issue(encode_ri(OP_ADDI, 12, 0, 20'h00005));
    issue(encode_rr(OP_MUL, 15, 12, 12));
    wait_idle();
    compare_regs();
    end_test("mul_hazard", errs);
  endtask

  task automatic burst_ordering();
    int      errs;
    reg_id_t rd;
    reg_id_t rs1;
    reg_id_t rs2;
    data_t   word;
    errs = err_count;
    for (int k = 0; k < 20; k++) begin
      rd  = reg_id_t'(1 + k % 6);
      rs1 = reg_id_t'(1 + (k + 2) % 6);
      rs2 = reg_id_t'(1 + (k + 4) % 6);
      case (k % 4)
        0:       word = encode_rr(OP_MUL, rd, rs1, rs2);
        1:       word = encode_ri(OP_ADDI, rd, rs1, 20'(k * 37 - 300));
        2:       word = encode_rr(OP_SUB, rd, rs1, rs2);
        default: word = encode_rr(OP_XOR, rd, rs1, rs2);
      endcase
      issue(word);
    end
    wait_idle();
    compare_regs();
    end_test("burst_ordering", errs);
  endtask

  task automatic random_program();
    int          errs;
    logic [31:0] sel;
    opcode_e     op;
    reg_id_t     rd;
    reg_id_t     rs1;
    errs = err_count;
    for (int k = 0; k < 40; k++) begin
      // redraw until one of the five opcodes comes up
      do begin
        sel = take_bits(3);
      end while (sel > 4);
      case (sel)
        0:       op = OP_ADD;
        1:       op = OP_SUB;
        2:       op = OP_XOR;
        3:       op = OP_ADDI;
        default: op = OP_MUL;
      endcase
      rd  = reg_id_t'(take_bits(4));
      rs1 = reg_id_t'(take_bits(4));
      if (op == OP_ADDI) begin
        issue(encode_ri(op, rd, rs1, 20'(take_bits(20))));
      end else begin
        issue(encode_rr(op, rd, rs1, reg_id_t'(take_bits(4))));
      end
    end
    wait_idle();
    compare_regs();
    end_test("random_program", errs);
  endtask

`endif

// File: dv/tb_top.sv
// ==================================================
// testbench for the issue subsystem
// clock, reset, wishbone master tasks, lfsr,
// compare task, watchdog and result summary
// ==================================================
`timescale 1ns/1ps

module tb_top
  import core_pkg::*;
  import isa_pkg::*;
();

  localparam int clk_period_c  = 4;
  localparam int mul_cycles_c  = 8;
  localparam int max_polls_c   = 32;
  // instruction writes over all tests, and reads incl. status polls
  localparam int instr_total_c = 81;
  localparam int read_total_c  = 6 * reg_els_c + 1 + 5 * max_polls_c;
  // a write may sit behind a full multiply before it is acked
  localparam int instr_worst_c = mul_cycles_c + 8;
  localparam int read_worst_c  = 4;
  localparam int watchdog_ns_c = 2 * clk_period_c
                               * (instr_total_c * instr_worst_c + read_total_c * read_worst_c);

  logic        clk = 1'b0;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  addr_t       wb_adr;
  data_t       wb_dat;
  data_t       wb_dat_o;
  logic        wb_ack;
  int          err_count;
  int          tests_passed;
  int          tests_failed;
  logic [31:0] lfsr_state;

  always #(clk_period_c / 2) clk = ~clk;

  iss_top #(
    .mul_cycles_p (mul_cycles_c)
  ) u_dut (
    .clk_i    (clk),
    .reset_i  (reset),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack)
  );

  // one classic cycle, stb stays low for a cycle before the next one
  task automatic wb_access(input logic we, input addr_t adr, input data_t wdata,
                           output data_t rdata);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= we;
    wb_adr <= adr;
    wb_dat <= wdata;
    do begin
      @(posedge clk);
    end while (!wb_ack);
    rdata = wb_dat_o;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input addr_t adr, input data_t wdata);
    data_t unused;
    wb_access(1'b1, adr, wdata, unused);
  endtask

  task automatic wb_read(input addr_t adr, output data_t rdata);
    wb_access(1'b0, adr, '0, rdata);
  endtask

  task automatic check(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  // galois form, taps for x^32 + x^30 + x^26 + x^25 + 1
  function automatic logic next_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'ha300_0000;
    end
    return out;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int k = 0; k < n; k++) begin
      val = {val[30:0], next_bit()};
    end
    return val;
  endfunction

  task automatic end_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      tests_passed++;
      $display("%-16s ok", name);
    end else begin
      tests_failed++;
      $display("%-16s %0d mismatches", name, err_count - errs_before);
    end
  endtask

`include "tb_tests.svh"

  initial begin
    #(watchdog_ns_c);
    $display("watchdog expired, tests still running after %0d ns", watchdog_ns_c);
    $display("Test failed");
    $finish;
  end

  initial begin
    reset        = 1'b0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat       = '0;
    err_count    = 0;
    tests_passed = 0;
    tests_failed = 0;
    lfsr_state   = 32'hbfad;
    repeat (2) @(posedge clk);
    reset <= 1'b1;
    reset_state();
    alu_chains();
    x0_handling();
    mul_hazard();
    burst_ordering();
    random_program();
    $display("summary: passed %0d, failed %0d, mismatches %0d",
             tests_passed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: rtl/iss_top.sv
// ==================================================
// issue subsystem top level
// wishbone slave ports, issue stage, scoreboard,
// register file, alu and multiplier
// ==================================================
`timescale 1ns/1ps

module iss_top
  import core_pkg::*;
#(
  parameter int mul_cycles_p = 8
) (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  wb_cyc_i,
  input  logic  wb_stb_i,
  input  logic  wb_we_i,
  input  addr_t wb_adr_i,
  input  data_t wb_dat_i,
  output data_t wb_dat_o,
  output logic  wb_ack_o
);

  // port 0 is the alu, port 1 the multiplier
  localparam int num_clear_port_p = 2;

  sb_if   sb ();
  exec_if alu_exe ();
  exec_if mul_exe ();
  wbk_if  wbk [num_clear_port_p] ();

  reg_id_t                        rs1_id;
  reg_id_t                        rs2_id;
  data_t                          rs1_data;
  data_t                          rs2_data;
  reg_id_t                        dbg_id;
  data_t                          dbg_data;
  logic                           sb_busy;
  logic    [num_clear_port_p-1:0] clr_v;
  reg_id_t [num_clear_port_p-1:0] clr_id;

  for (genvar g = 0; g < num_clear_port_p; g++) begin : g_clr
    assign clr_v[g]  = wbk[g].valid;
    assign clr_id[g] = wbk[g].rd;
  end

  issue_stage u_issue (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .sb_o       (sb),
    .alu_o      (alu_exe),
    .mul_o      (mul_exe),
    .rs1_id_o   (rs1_id),
    .rs2_id_o   (rs2_id),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .dbg_id_o   (dbg_id),
    .dbg_data_i (dbg_data),
    .sb_busy_i  (sb_busy)
  );

  scoreboard #(
    .num_clear_port_p (num_clear_port_p)
  ) u_sb (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .sb_i       (sb),
    .clear_i    (clr_v),
    .clear_id_i (clr_id),
    .busy_o     (sb_busy)
  );

  regfile #(
    .num_clear_port_p (num_clear_port_p)
  ) u_rf (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rs1_id_i   (rs1_id),
    .rs2_id_i   (rs2_id),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .dbg_id_i   (dbg_id),
    .dbg_data_o (dbg_data),
    .wbk_i      (wbk)
  );

  exec_alu u_alu (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .exe_i   (alu_exe),
    .wbk_o   (wbk[0])
  );

  exec_mul #(
    .mul_cycles_p (mul_cycles_p)
  ) u_mul (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .exe_i   (mul_exe),
    .wbk_o   (wbk[1])
  );

endmodule

// File: rtl/exec_mul.sv
// ==================================================
// iterative shift-and-add multiplier
// low 32 bits of the unsigned product
// writeback mul_cycles_p cycles after transfer
// ==================================================
`timescale 1ns/1ps

module exec_mul
  import core_pkg::*;
#(
  parameter int mul_cycles_p = 8
) (
  input logic   clk_i,
  input logic   reset_i,
  exec_if.unit  exe_i,
  wbk_if.source wbk_o
);

  localparam int step_bits_lp = (data_w_c + mul_cycles_p - 1) / mul_cycles_p;
  localparam int cnt_w_lp     = $clog2(mul_cycles_p);

  logic                busy_r;
  logic                valid_r;
  logic [cnt_w_lp-1:0] cnt_r;
  reg_id_t             rd_r;
  data_t               acc_r;
  data_t               mcand_r;
  data_t               mplier_r;
  logic                start;
  logic                last;
  data_t               mcand_cur;
  data_t               mplier_cur;
  data_t               acc_cur;
  data_t               partial;

  assign exe_i.ready = ~busy_r;
  assign start       = exe_i.valid & ~busy_r;
  assign last        = busy_r & (cnt_r == cnt_w_lp'(1));

  // first step runs on the transfer edge
  assign mcand_cur  = start ? exe_i.operand_a : mcand_r;
  assign mplier_cur = start ? exe_i.operand_b : mplier_r;
  assign acc_cur    = start ? '0 : acc_r;

  always_comb begin
    partial = '0;
    for (int j = 0; j < step_bits_lp; j++) begin
      if (mplier_cur[j]) begin
        partial = partial + (mcand_cur << j);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      busy_r  <= 1'b0;
      valid_r <= 1'b0;
      cnt_r   <= '0;
    end else begin
      valid_r <= last;
      if (start) begin
        busy_r <= 1'b1;
        cnt_r  <= cnt_w_lp'(mul_cycles_p - 1);
      end else if (busy_r) begin
        busy_r <= ~last;
        cnt_r  <= cnt_r - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      rd_r <= exe_i.rd;
    end
    if (start || busy_r) begin
      acc_r    <= acc_cur + partial;
      mcand_r  <= mcand_cur << step_bits_lp;
      mplier_r <= mplier_cur >> step_bits_lp;
    end
  end

  assign wbk_o.valid = valid_r;
  assign wbk_o.rd    = rd_r;
  assign wbk_o.data  = acc_r;

endmodule

// File: rtl/exec_alu.sv
// ==================================================
// single-cycle alu: add, sub, xor, addi
// result registered for writeback
// ==================================================
`timescale 1ns/1ps

module exec_alu
  import core_pkg::*;
  import isa_pkg::*;
(
  input logic   clk_i,
  input logic   reset_i,
  exec_if.unit  exe_i,
  wbk_if.source wbk_o
);

  data_t   result;
  logic    valid_r;
  reg_id_t rd_r;
  data_t   data_r;

  assign exe_i.ready = 1'b1;

  // wrapped 32-bit arithmetic
  always_comb begin
    case (exe_i.op)
      OP_ADD, OP_ADDI: result = exe_i.operand_a + exe_i.operand_b;
      OP_SUB:          result = exe_i.operand_a - exe_i.operand_b;
      OP_XOR:          result = exe_i.operand_a ^ exe_i.operand_b;
      default:         result = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      valid_r <= 1'b0;
    end else begin
      valid_r <= exe_i.valid & exe_i.ready;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exe_i.valid) begin
      rd_r   <= exe_i.rd;
      data_r <= result;
    end
  end

  assign wbk_o.valid = valid_r;
  assign wbk_o.rd    = rd_r;
  assign wbk_o.data  = data_r;

endmodule

// File: rtl/regfile.sv
// ==================================================
// 16 x 32 register file, x0 reads zero
// two operand reads, one debug read
// one write port per writeback, with write-through
// ==================================================
`timescale 1ns/1ps

module regfile
  import core_pkg::*;
#(
  parameter int num_clear_port_p = 1
) (
  input  logic    clk_i,
  input  logic    reset_i,
  input  reg_id_t rs1_id_i,
  input  reg_id_t rs2_id_i,
  output data_t   rs1_data_o,
  output data_t   rs2_data_o,
  input  reg_id_t dbg_id_i,
  output data_t   dbg_data_o,
  wbk_if.sink     wbk_i [num_clear_port_p]
);

  data_t   [reg_els_c-1:0]        regs_r;
  logic    [num_clear_port_p-1:0] wr_v;
  reg_id_t [num_clear_port_p-1:0] wr_id;
  data_t   [num_clear_port_p-1:0] wr_data;

  for (genvar g = 0; g < num_clear_port_p; g++) begin : g_wr
    assign wr_v[g]    = wbk_i[g].valid;
    assign wr_id[g]   = wbk_i[g].rd;
    assign wr_data[g] = wbk_i[g].data;
  end

  // stored value, overridden by a write landing this cycle
  function automatic data_t read_port(
    input reg_id_t                        id,
    input data_t   [reg_els_c-1:0]        regs,
    input logic    [num_clear_port_p-1:0] v,
    input reg_id_t [num_clear_port_p-1:0] wid,
    input data_t   [num_clear_port_p-1:0] wdata
  );
    data_t val;
    val = regs[id];
    for (int p = 0; p < num_clear_port_p; p++) begin
      if (v[p] && wid[p] == id) begin
        val = wdata[p];
      end
    end
    if (id == '0) begin
      val = '0;
    end
    return val;
  endfunction

  assign rs1_data_o = read_port(rs1_id_i, regs_r, wr_v, wr_id, wr_data);
  assign rs2_data_o = read_port(rs2_id_i, regs_r, wr_v, wr_id, wr_data);
  assign dbg_data_o = read_port(dbg_id_i, regs_r, wr_v, wr_id, wr_data);

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      regs_r <= '0;
    end else begin
      for (int p = 0; p < num_clear_port_p; p++) begin
        if (wr_v[p] && wr_id[p] != '0) begin
          regs_r[wr_id[p]] <= wr_data[p];
        end
      end
    end
  end

endmodule

// File: rtl/scoreboard.sv
// ==================================================
// pending bit per register, x0 never scored
// score with priority over multi-port clear
// raw and waw dependency check
// ==================================================
`timescale 1ns/1ps

module scoreboard
  import core_pkg::*;
#(
  parameter int num_clear_port_p = 1
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  sb_if.tbl                             sb_i,
  input  logic [num_clear_port_p-1:0]   clear_i,
  input  reg_id_t [num_clear_port_p-1:0] clear_id_i,
  output logic                          busy_o
);

  logic [reg_els_c-1:0] pending_r;
  logic [reg_els_c-1:0] score_bits;
  logic [reg_els_c-1:0] clear_bits;
  logic [1:0]           dep_src;
  logic                 dep_dest;

  always_comb begin
    score_bits = '0;
    if (sb_i.score && sb_i.score_id != '0) begin
      score_bits[sb_i.score_id] = 1'b1;
    end
  end

  // merge all writeback ports into one clear mask
  always_comb begin
    clear_bits = '0;
    for (int p = 0; p < num_clear_port_p; p++) begin
      if (clear_i[p]) begin
        clear_bits[clear_id_i[p]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      pending_r <= '0;
    end else begin
      pending_r <= score_bits | (pending_r & ~clear_bits);
    end
  end

  // the id scored this cycle belongs to the instruction under lookup,
  // so only the registered bits can block it
  for (genvar i = 0; i < 2; i++) begin : g_src
    assign dep_src[i] = sb_i.src_rd[i] & pending_r[sb_i.src_id[i]]
                      & ~clear_bits[sb_i.src_id[i]];
  end

  assign dep_dest = sb_i.dest_wr & pending_r[sb_i.dest_id] & ~clear_bits[sb_i.dest_id];

  assign sb_i.dependency = (|dep_src) | dep_dest;
  assign busy_o          = |pending_r;

endmodule

// File: rtl/issue_stage.sv
// ==================================================
// wishbone slave for instruction and status access
// single-entry holding register and decode
// hazard stall and dispatch to alu or multiplier
// ==================================================
`timescale 1ns/1ps

module issue_stage
  import core_pkg::*;
  import isa_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    wb_cyc_i,
  input  logic    wb_stb_i,
  input  logic    wb_we_i,
  input  addr_t   wb_adr_i,
  input  data_t   wb_dat_i,
  output data_t   wb_dat_o,
  output logic    wb_ack_o,
  sb_if.lookup    sb_o,
  exec_if.issuer  alu_o,
  exec_if.issuer  mul_o,
  output reg_id_t rs1_id_o,
  output reg_id_t rs2_id_o,
  input  data_t   rs1_data_i,
  input  data_t   rs2_data_i,
  output reg_id_t dbg_id_o,
  input  data_t   dbg_data_i,
  input  logic    sb_busy_i
);

  instr_u instr_r;
  logic   held_r;
  logic   bus_req;
  logic   instr_wr;
  logic   bus_accept;
  logic   is_alu;
  logic   is_mul;
  logic   is_addi;
  logic   clear_to_go;
  logic   retire;
  data_t  imm_ext;
  data_t  status;
  data_t  rd_data;

  // ack is a one-cycle pulse, so a request seen under ack is the old one
  assign bus_req    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign instr_wr   = bus_req & wb_we_i & (wb_adr_i == addr_instr_c);
  assign bus_accept = bus_req & ~(instr_wr & held_r);

  always_comb begin
    case (instr_r.r.opcode)
      OP_ADD, OP_SUB, OP_XOR, OP_ADDI: is_alu = 1'b1;
      default:                         is_alu = 1'b0;
    endcase
  end

  assign is_mul  = (instr_r.r.opcode == OP_MUL);
  assign is_addi = (instr_r.i.opcode == OP_ADDI);
  assign imm_ext = {{(data_w_c - $bits(instr_r.i.imm)){instr_r.i.imm[19]}}, instr_r.i.imm};

  // addi has no rs2, so its read request is dropped
  assign rs1_id_o = instr_r.r.rs1;
  assign rs2_id_o = is_addi ? '0 : instr_r.r.rs2;

  assign sb_o.src_id[0] = instr_r.r.rs1;
  assign sb_o.src_id[1] = rs2_id_o;
  assign sb_o.src_rd[0] = is_alu | is_mul;
  assign sb_o.src_rd[1] = (is_alu | is_mul) & ~is_addi;
  assign sb_o.dest_id   = instr_r.r.rd;
  assign sb_o.dest_wr   = is_alu | is_mul;

  assign clear_to_go = held_r & ~sb_o.dependency;

  assign alu_o.valid     = clear_to_go & is_alu;
  assign alu_o.op        = instr_r.r.opcode;
  assign alu_o.rd        = instr_r.r.rd;
  assign alu_o.operand_a = rs1_data_i;
  assign alu_o.operand_b = is_addi ? imm_ext : rs2_data_i;

  assign mul_o.valid     = clear_to_go & is_mul;
  assign mul_o.op        = instr_r.r.opcode;
  assign mul_o.rd        = instr_r.r.rd;
  assign mul_o.operand_a = rs1_data_i;
  assign mul_o.operand_b = rs2_data_i;

  // score on transfer, x0 is filtered by the scoreboard
  assign sb_o.score    = (alu_o.valid & alu_o.ready) | (mul_o.valid & mul_o.ready);
  assign sb_o.score_id = instr_r.r.rd;

  // unknown opcodes leave without touching a unit
  assign retire = sb_o.score | (clear_to_go & ~is_alu & ~is_mul);

  always_comb begin
    status = '0;
    status[status_busy_c] = sb_busy_i | held_r;
  end

  assign dbg_id_o = wb_adr_i[reg_id_w_c-1:0];

  always_comb begin
    rd_data = '0;
    if (wb_adr_i >= addr_reg_base_c) begin
      rd_data = dbg_data_i;
    end else if (wb_adr_i == addr_status_c) begin
      rd_data = status;
    end else if (wb_adr_i == addr_instr_c) begin
      rd_data = instr_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      wb_ack_o <= 1'b0;
      held_r   <= 1'b0;
    end else begin
      wb_ack_o <= bus_accept;
      if (instr_wr && !held_r) begin
        held_r <= 1'b1;
      end else if (retire) begin
        held_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_wr && !held_r) begin
      instr_r <= wb_dat_i;
    end
    if (bus_accept) begin
      wb_dat_o <= rd_data;
    end
  end

endmodule

// File: rtl/core_if.sv
// ==================================================
// sb_if   scoreboard lookup and score
// exec_if issue to execution unit handshake
// wbk_if  execution unit writeback
// ==================================================
`timescale 1ns/1ps

interface sb_if
  import core_pkg::*;
();

  // index 0 is rs1, index 1 is rs2
  reg_id_t [1:0] src_id;
  logic    [1:0] src_rd;
  reg_id_t       dest_id;
  logic          dest_wr;
  logic          score;
  reg_id_t       score_id;
  logic          dependency;

  modport lookup (
    output src_id, src_rd, dest_id, dest_wr, score, score_id,
    input  dependency
  );

  modport tbl (
    input  src_id, src_rd, dest_id, dest_wr, score, score_id,
    output dependency
  );

endinterface

interface exec_if
  import core_pkg::*;
  import isa_pkg::*;
();

  logic    valid;
  opcode_e op;
  reg_id_t rd;
  data_t   operand_a;
  data_t   operand_b;
  logic    ready;

  modport issuer (output valid, op, rd, operand_a, operand_b, input ready);
  modport unit (input valid, op, rd, operand_a, operand_b, output ready);

endinterface

interface wbk_if
  import core_pkg::*;
();

  logic    valid;
  reg_id_t rd;
  data_t   data;

  modport source (output valid, rd, data);
  modport sink (input valid, rd, data);

endinterface

// File: rtl/isa_pkg.sv
// ==================================================
// opcode encodings for the issue subsystem
// register-register and register-immediate formats
// union used to decode one word both ways
// ==================================================
package isa_pkg;

  // any other encoding retires as a no-op
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_XOR  = 4'h2,
    OP_ADDI = 4'h3,
    OP_MUL  = 4'h4
  } opcode_e;

  typedef logic [3:0] reg_field_t;

  // register-register form, low half unused
  typedef struct packed {
    opcode_e     opcode;
    reg_field_t  rd;
    reg_field_t  rs1;
    reg_field_t  rs2;
    logic [15:0] unused;
  } instr_r_t;

  // register-immediate form, imm is sign-extended on use
  typedef struct packed {
    opcode_e     opcode;
    reg_field_t  rd;
    reg_field_t  rs1;
    logic [19:0] imm;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

endpackage

// File: rtl/core_pkg.sv
// ==================================================
// register file geometry and data width
// bus word address map
// status word bit positions
// ==================================================
package core_pkg;

  localparam int reg_els_c  = 16;
  localparam int reg_id_w_c = $clog2(reg_els_c);
  localparam int data_w_c   = 32;
  localparam int addr_w_c   = 5;

  typedef logic [reg_id_w_c-1:0] reg_id_t;
  typedef logic [data_w_c-1:0]   data_t;
  typedef logic [addr_w_c-1:0]   addr_t;

  // word addresses, 16..31 map onto x0..x15
  localparam addr_t addr_instr_c    = 5'd0;
  localparam addr_t addr_status_c   = 5'd1;
  localparam addr_t addr_reg_base_c = 5'd16;

  // set while an instruction is held or any register is scored
  localparam int status_busy_c = 0;

endpackage
